/* rtl/id_config.svh */
// RV32I widths only; the immediate layouts are fixed to a 32-bit word
// The decoder drives exactly two read ports (rs1, rs2)
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Data path and PC width
`define ID_XLEN 32

// Register address width, 32 integer registers
`define ID_RAW 5

// Source read ports
`define ID_NUM_RS 2

// Link increment, no compressed instructions
`define ID_PC_STEP 4

`endif

/* rtl/id_pkg.sv */
// Shared types of the decode stage
// Enum encodings are visible on the EX payload and in the test patterns
`default_nettype none
`include "id_config.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0] word_t;
  typedef logic [`ID_RAW-1:0]  raddr_t;

  // Major opcodes of the supported base instructions
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic ops first, branch compares after
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_RS1, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_RS2, OP_B_IMM, OP_B_PCSTEP} op_b_sel_e;
  typedef enum logic {OP_C_RS2, OP_C_BRANCH} op_c_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // Decoder output, consumed within the stage
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    imm_sel_e  imm_sel;
    logic      rf_we;
    raddr_t    rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    logic [1:0] lsu_size;
    logic      lsu_sext;
    logic      jump;
    logic      jump_reg;
    logic      branch;
    logic      illegal;
  } dec_ctrl_t;

  // Contents of the ID/EX register
  typedef struct packed {
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    word_t      pc;
    logic       rf_we;
    raddr_t     rf_waddr;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_sext;
    logic       illegal;
  } id_ex_t;

endpackage

`default_nettype wire

/* rtl/fwd_if.sv */
// Writeback state of EX and WB as seen by the decode bypass units
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

interface fwd_if;

  // EX result; a load there has no data yet
  logic                ex_we;
  logic                ex_load;
  logic [`ID_RAW-1:0]  ex_waddr;
  logic [`ID_XLEN-1:0] ex_wdata;

  // WB result, always complete
  logic                wb_we;
  logic [`ID_RAW-1:0]  wb_waddr;
  logic [`ID_XLEN-1:0] wb_wdata;

  modport src (output ex_we, ex_load, ex_waddr, ex_wdata, wb_we, wb_waddr, wb_wdata);
  modport dst (input  ex_we, ex_load, ex_waddr, ex_wdata, wb_we, wb_waddr, wb_wdata);

endinterface

`default_nettype wire

/* rtl/instr_decoder.sv */
// RV32I base opcodes only; FENCE, SYSTEM and all extensions decode as illegal
// Assumes exactly two source ports
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module instr_decoder (
  input  logic [`ID_XLEN-1:0]   instr_i,
  output id_pkg::dec_ctrl_t     ctrl_o,
  output id_pkg::raddr_t        rs_addr_o [`ID_NUM_RS],
  output logic [`ID_NUM_RS-1:0] rs_re_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  // Register/immediate arithmetic by funct3, alt picks SUB or SRA
  function automatic id_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign f7_zero = (funct7 == 7'b000_0000);
  assign f7_alt  = (funct7 == 7'b010_0000);

  // rs1 and rs2 sit at fixed bit positions in every format
  assign rs_addr_o[0] = instr_i[19:15];
  assign rs_addr_o[1] = instr_i[24:20];

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    // Defaults describe an I-type ALU op with no side effects
    ctrl_o          = '0;
    ctrl_o.alu_op   = id_pkg::ALU_ADD;
    ctrl_o.op_a_sel = id_pkg::OP_A_RS1;
    ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
    ctrl_o.op_c_sel = id_pkg::OP_C_RS2;
    ctrl_o.imm_sel  = id_pkg::IMM_I;
    ctrl_o.rf_waddr = instr_i[11:7];
    // Size and sign come straight from funct3 for loads and stores
    ctrl_o.lsu_size = funct3[1:0];
    ctrl_o.lsu_sext = !funct3[2];
    rs_re_o         = '0;

    case (opcode)
      id_pkg::OPC_OP: begin
        ctrl_o.alu_op   = alu_op_of(funct3, funct7[5]);
        ctrl_o.op_b_sel = id_pkg::OP_B_RS2;
        ctrl_o.rf_we    = 1'b1;
        rs_re_o[0]      = 1'b1;
        rs_re_o[1]      = 1'b1;
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        ctrl_o.illegal  = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      id_pkg::OPC_OP_IMM: begin
        // funct7 is immediate data except for the shifts
        ctrl_o.alu_op = alu_op_of(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl_o.rf_we  = 1'b1;
        rs_re_o[0]    = 1'b1;
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = !(f7_zero || f7_alt);
        end
      end
      id_pkg::OPC_LUI: begin
        ctrl_o.op_a_sel = id_pkg::OP_A_ZERO;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        ctrl_o.op_a_sel = id_pkg::OP_A_PC;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        // ALU computes the link, target comes from operand_select
        ctrl_o.op_a_sel = id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = id_pkg::OP_B_PCSTEP;
        ctrl_o.imm_sel  = id_pkg::IMM_J;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.jump     = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        ctrl_o.op_a_sel = id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = id_pkg::OP_B_PCSTEP;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.jump     = 1'b1;
        ctrl_o.jump_reg = 1'b1;
        rs_re_o[0]      = 1'b1;
        ctrl_o.illegal  = (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        ctrl_o.op_b_sel = id_pkg::OP_B_RS2;
        ctrl_o.op_c_sel = id_pkg::OP_C_BRANCH;
        ctrl_o.imm_sel  = id_pkg::IMM_B;
        ctrl_o.branch   = 1'b1;
        rs_re_o[0]      = 1'b1;
        rs_re_o[1]      = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = id_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = id_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = id_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = id_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = id_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = id_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        ctrl_o.lsu_en  = 1'b1;
        ctrl_o.rf_we   = 1'b1;
        rs_re_o[0]     = 1'b1;
        // LB LH LW LBU LHU
        ctrl_o.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      id_pkg::OPC_STORE: begin
        ctrl_o.imm_sel = id_pkg::IMM_S;
        ctrl_o.lsu_en  = 1'b1;
        ctrl_o.lsu_we  = 1'b1;
        rs_re_o[0]     = 1'b1;
        rs_re_o[1]     = 1'b1;
        ctrl_o.illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words must not write, access memory, jump or read
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.jump     = 1'b0;
      ctrl_o.jump_reg = 1'b0;
      ctrl_o.branch   = 1'b0;
      rs_re_o         = '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
// Base RV32I immediate formats only, all sign extended from bit 31
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module imm_gen (
  input  logic [`ID_XLEN-1:0] instr_i,
  input  id_pkg::imm_sel_e    imm_sel_i,
  output logic [`ID_XLEN-1:0] imm_o
);

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // B and J carry halfword offsets, bit 0 always zero
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (imm_sel_i)
      id_pkg::IMM_S: imm_o = imm_s;
      id_pkg::IMM_B: imm_o = imm_b;
      id_pkg::IMM_U: imm_o = imm_u;
      id_pkg::IMM_J: imm_o = imm_j;
      default:       imm_o = imm_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
// One source read port; rf_rdata_i must be valid in the same cycle as raddr_i
// A load in EX cannot be forwarded, the port reports a hazard instead
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
  input  logic           re_i,
  input  id_pkg::raddr_t raddr_i,
  input  id_pkg::word_t  rf_rdata_i,
  fwd_if.dst             fwd,
  output id_pkg::word_t  operand_o,
  output logic           hazard_o
);

  logic addr_live;
  logic ex_hit;
  logic wb_hit;

  // x0 and unused ports never match a writer
  assign addr_live = re_i && (raddr_i != '0);
  assign ex_hit    = addr_live && fwd.ex_we && (fwd.ex_waddr == raddr_i);
  assign wb_hit    = addr_live && fwd.wb_we && (fwd.wb_waddr == raddr_i);

  // Load data arrives too late for this cycle
  assign hazard_o = ex_hit && fwd.ex_load;

  ////////////////////////////////////////
  // Forwarding priority
  ////////////////////////////////////////

  always_comb begin
    if (!addr_live) begin
      operand_o = '0;
    end else if (ex_hit && !fwd.ex_load) begin
      // Youngest result wins
      operand_o = fwd.ex_wdata;
    end else if (wb_hit) begin
      operand_o = fwd.wb_wdata;
    end else begin
      operand_o = rf_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
// Operand muxes and target adders; the JALR target uses the forwarded rs1
// jmp_target_o is only meaningful while a JAL or JALR is presented
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module operand_select (
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::word_t     imm_i,
  input  id_pkg::word_t     rs1_i,
  input  id_pkg::word_t     rs2_i,
  output id_pkg::word_t     operand_a_o,
  output id_pkg::word_t     operand_b_o,
  output id_pkg::word_t     operand_c_o,
  output id_pkg::word_t     jmp_target_o
);

  id_pkg::word_t bch_target;
  id_pkg::word_t jmp_base;
  id_pkg::word_t jmp_sum;

  ////////////////////////////////////////
  // Target adders
  ////////////////////////////////////////

  // imm_i is the B immediate when a branch is decoded
  assign bch_target = pc_i + imm_i;

  // JAL is PC relative, JALR is register relative
  assign jmp_base = ctrl_i.jump_reg ? rs1_i : pc_i;
  assign jmp_sum  = jmp_base + imm_i;
  // JALR clears the low bit of the sum
  assign jmp_target_o = {jmp_sum[`ID_XLEN-1:1], jmp_sum[0] & !ctrl_i.jump_reg};

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pkg::OP_A_PC:   operand_a_o = pc_i;
      id_pkg::OP_A_ZERO: operand_a_o = '0;
      default:           operand_a_o = rs1_i;
    endcase

    case (ctrl_i.op_b_sel)
      id_pkg::OP_B_RS2:    operand_b_o = rs2_i;
      // Link value for the jumps
      id_pkg::OP_B_PCSTEP: operand_b_o = id_pkg::word_t'(`ID_PC_STEP);
      default:             operand_b_o = imm_i;
    endcase

    // Store data or branch target
    if (ctrl_i.op_c_sel == id_pkg::OP_C_BRANCH) begin
      operand_c_o = bch_target;
    end else begin
      operand_c_o = rs2_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/id_ex_register.sv */
// Single-entry ID/EX register; ready_o combinationally follows ready_i and hazard_i
// Payload is held while valid_o is high and ready_i is low
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module id_ex_register (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_i,
  input  logic [`ID_NUM_RS-1:0] hazard_i,
  output logic                  ready_o,
  input  id_pkg::id_ex_t        payload_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output id_pkg::id_ex_t        payload_o
);

  logic accept;

  // Room when empty or draining this cycle; any load-use hazard blocks the stage
  assign ready_o = (!valid_o || ready_i) && !(|hazard_i);
  assign accept  = valid_i && ready_o;

  ////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else if (accept) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      // EX took the item and nothing replaced it
      valid_o <= 1'b0;
    end
  end

  // Payload changes only on an accepted transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      payload_o <= payload_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
// Decode stage top; register file is external and must answer combinationally
// instr_i and pc_i must hold while instr_valid_i is high and id_ready_o is low
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module id_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  // Fetch side handshake
  input  logic                  instr_valid_i,
  input  logic [`ID_XLEN-1:0]   instr_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  output logic                  id_ready_o,
  // Register file read ports
  output logic [`ID_NUM_RS-1:0] rf_re_o,
  output logic [`ID_RAW-1:0]    rf_raddr_o [`ID_NUM_RS],
  input  logic [`ID_XLEN-1:0]   rf_rdata_i [`ID_NUM_RS],
  // Writeback state for forwarding
  input  logic                  ex_we_i,
  input  logic                  ex_load_i,
  input  logic [`ID_RAW-1:0]    ex_waddr_i,
  input  logic [`ID_XLEN-1:0]   ex_wdata_i,
  input  logic                  wb_we_i,
  input  logic [`ID_RAW-1:0]    wb_waddr_i,
  input  logic [`ID_XLEN-1:0]   wb_wdata_i,
  output logic [`ID_XLEN-1:0]   jmp_target_o,
  // EX side handshake and payload
  output logic                  ex_valid_o,
  input  logic                  ex_ready_i,
  output logic [3:0]            ex_alu_op_o,
  output logic [`ID_XLEN-1:0]   ex_operand_a_o,
  output logic [`ID_XLEN-1:0]   ex_operand_b_o,
  output logic [`ID_XLEN-1:0]   ex_operand_c_o,
  output logic [`ID_XLEN-1:0]   ex_pc_o,
  output logic                  ex_rf_we_o,
  output logic [`ID_RAW-1:0]    ex_rf_waddr_o,
  output logic                  ex_lsu_en_o,
  output logic                  ex_lsu_we_o,
  output logic [1:0]            ex_lsu_size_o,
  output logic                  ex_lsu_sext_o,
  output logic                  ex_illegal_o
);

  id_pkg::dec_ctrl_t     ctrl;
  id_pkg::word_t         imm;
  id_pkg::word_t         rs_operand [`ID_NUM_RS];
  logic [`ID_NUM_RS-1:0] hazard;
  id_pkg::word_t         operand_a;
  id_pkg::word_t         operand_b;
  id_pkg::word_t         operand_c;
  id_pkg::id_ex_t        ex_d;
  id_pkg::id_ex_t        ex_q;

  ////////////////////////////////////////
  // Decode and immediates
  ////////////////////////////////////////

  instr_decoder u_decoder (
    .instr_i   (instr_i),
    .ctrl_o    (ctrl),
    .rs_addr_o (rf_raddr_o),
    .rs_re_o   (rf_re_o)
  );

  imm_gen u_imm_gen (
    .instr_i   (instr_i),
    .imm_sel_i (ctrl.imm_sel),
    .imm_o     (imm)
  );

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  // Source side of the bus is driven from the plain ports
  fwd_if u_fwd ();

  assign u_fwd.ex_we    = ex_we_i;
  assign u_fwd.ex_load  = ex_load_i;
  assign u_fwd.ex_waddr = ex_waddr_i;
  assign u_fwd.ex_wdata = ex_wdata_i;
  assign u_fwd.wb_we    = wb_we_i;
  assign u_fwd.wb_waddr = wb_waddr_i;
  assign u_fwd.wb_wdata = wb_wdata_i;

  for (genvar i = 0; i < `ID_NUM_RS; i++) begin : gen_bypass
    operand_bypass u_bypass (
      .re_i       (rf_re_o[i]),
      .raddr_i    (rf_raddr_o[i]),
      .rf_rdata_i (rf_rdata_i[i]),
      .fwd        (u_fwd),
      .operand_o  (rs_operand[i]),
      .hazard_o   (hazard[i])
    );
  end

  operand_select u_opsel (
    .ctrl_i       (ctrl),
    .pc_i         (pc_i),
    .imm_i        (imm),
    .rs1_i        (rs_operand[0]),
    .rs2_i        (rs_operand[1]),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  assign ex_d.alu_op    = ctrl.alu_op;
  assign ex_d.operand_a = operand_a;
  assign ex_d.operand_b = operand_b;
  assign ex_d.operand_c = operand_c;
  assign ex_d.pc        = pc_i;
  assign ex_d.rf_we     = ctrl.rf_we;
  assign ex_d.rf_waddr  = ctrl.rf_waddr;
  assign ex_d.lsu_en    = ctrl.lsu_en;
  assign ex_d.lsu_we    = ctrl.lsu_we;
  assign ex_d.lsu_size  = ctrl.lsu_size;
  assign ex_d.lsu_sext  = ctrl.lsu_sext;
  assign ex_d.illegal   = ctrl.illegal;

  id_ex_register u_id_ex (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (instr_valid_i),
    .hazard_i  (hazard),
    .ready_o   (id_ready_o),
    .payload_i (ex_d),
    .valid_o   (ex_valid_o),
    .ready_i   (ex_ready_i),
    .payload_o (ex_q)
  );

  // Flatten the payload onto the EX ports
  assign ex_alu_op_o    = ex_q.alu_op;
  assign ex_operand_a_o = ex_q.operand_a;
  assign ex_operand_b_o = ex_q.operand_b;
  assign ex_operand_c_o = ex_q.operand_c;
  assign ex_pc_o        = ex_q.pc;
  assign ex_rf_we_o     = ex_q.rf_we;
  assign ex_rf_waddr_o  = ex_q.rf_waddr;
  assign ex_lsu_en_o    = ex_q.lsu_en;
  assign ex_lsu_we_o    = ex_q.lsu_we;
  assign ex_lsu_size_o  = ex_q.lsu_size;
  assign ex_lsu_sext_o  = ex_q.lsu_sext;
  assign ex_illegal_o   = ex_q.illegal;

endmodule

`default_nettype wire

/* verif/id_stage_props.sv */
// Bound into id_ex_register; checks handshake and reset behavior only
// assert_errors holds the number of failed assertions
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module id_stage_props (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  valid_i,
  input wire logic [`ID_NUM_RS-1:0] hazard_i,
  input wire logic                  valid_o,
  input wire logic                  ready_i,
  input wire id_pkg::id_ex_t        payload_o
);

  int assert_errors = 0;

  // Output register is empty while reset is held
  a_reset_empty: assert property (@(posedge clk) !rst_n |-> !valid_o)
    else begin
      assert_errors++;
      $error("ex valid high during reset");
    end

  // Held item stays put under back-pressure
  a_payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> valid_o && $stable(payload_o))
    else begin
      assert_errors++;
      $error("payload changed under back-pressure");
    end

  // Load-use hazard keeps the offered instruction out of the register
  a_hazard_block: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && (|hazard_i) |=> $stable(payload_o) && ($past(valid_o) || !valid_o))
    else begin
      assert_errors++;
      $error("instruction accepted during load-use hazard");
    end

endmodule

bind id_ex_register id_stage_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .valid_i   (valid_i),
  .hazard_i  (hazard_i),
  .valid_o   (valid_o),
  .ready_i   (ready_i),
  .payload_o (payload_o)
);

`default_nettype wire

/* verif/tb_id_stage.sv */
// One instruction in flight at a time; patterns come from verif/id_stage_patterns.hex
// A hazard pattern is held 3 cycles, then the EX load is withdrawn
`timescale 1ns/1ps
`default_nettype none
`include "id_config.svh"

module tb_id_stage;

  localparam int NUM_PAT   = 19;
  localparam int PAT_WORDS = 24;
  localparam int MAX_CYC   = NUM_PAT * 20 + 100;
  localparam int HOLD_CYC  = 3;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  logic [`ID_XLEN-1:0]   instr_i;
  logic [`ID_XLEN-1:0]   pc_i;
  logic                  id_ready_o;
  logic [`ID_NUM_RS-1:0] rf_re_o;
  logic [`ID_RAW-1:0]    rf_raddr_o [`ID_NUM_RS];
  logic [`ID_XLEN-1:0]   rf_rdata_i [`ID_NUM_RS];
  logic                  ex_we_i;
  logic                  ex_load_i;
  logic [`ID_RAW-1:0]    ex_waddr_i;
  logic [`ID_XLEN-1:0]   ex_wdata_i;
  logic                  wb_we_i;
  logic [`ID_RAW-1:0]    wb_waddr_i;
  logic [`ID_XLEN-1:0]   wb_wdata_i;
  logic [`ID_XLEN-1:0]   jmp_target_o;
  logic                  ex_valid_o;
  logic                  ex_ready_i;
  logic [3:0]            ex_alu_op_o;
  logic [`ID_XLEN-1:0]   ex_operand_a_o;
  logic [`ID_XLEN-1:0]   ex_operand_b_o;
  logic [`ID_XLEN-1:0]   ex_operand_c_o;
  logic [`ID_XLEN-1:0]   ex_pc_o;
  logic                  ex_rf_we_o;
  logic [`ID_RAW-1:0]    ex_rf_waddr_o;
  logic                  ex_lsu_en_o;
  logic                  ex_lsu_we_o;
  logic [1:0]            ex_lsu_size_o;
  logic                  ex_lsu_sext_o;
  logic                  ex_illegal_o;

  logic [31:0] pat_mem [NUM_PAT*PAT_WORDS];
  logic [31:0] lcg_state = 32'ha3ed_e655;
  logic        rand_bp   = 1'b0;
  int          errors    = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          cycles    = 0;

  id_stage DUT (.*);

  ////////////////////////////////////////
  // Clock, register file, timeout
  ////////////////////////////////////////

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Register file contents follow the address
  function automatic logic [31:0] rf_value(input logic [`ID_RAW-1:0] addr);
    if (addr == '0) begin
      return 32'h0;
    end
    return 32'h1000_0000 + 32'(addr) * 32'h11;
  endfunction

  always_comb begin
    for (int i = 0; i < `ID_NUM_RS; i++) begin
      rf_rdata_i[i] = rf_value(rf_raddr_o[i]);
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Source reads by instruction format; an illegal word reads nothing
  function automatic logic [1:0] reads_of(input logic [6:0] opc, input logic illegal);
    if (illegal) begin
      return 2'b00;
    end
    case (opc)
      7'h33, 7'h63, 7'h23: return 2'b11;
      7'h13, 7'h67, 7'h03: return 2'b01;
      default:             return 2'b00;
    endcase
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYC) begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Falling edge; EX ready is redrawn each cycle
  task automatic next_cycle();
    @(negedge clk);
    if (rand_bp) begin
      lcg_state  = lcg_next(lcg_state);
      ex_ready_i = lcg_state[31];
    end else begin
      ex_ready_i = 1'b1;
    end
  endtask

  // A different word is offered while EX stalls, it must stay out
  task automatic offer_while_ex_stalls(input int base);
    instr_valid_i = !ex_ready_i;
    instr_i       = ~pat_mem[base+1];
    pc_i          = ~pat_mem[base+2];
    #1;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_forwarding();
    ex_we_i    = 1'b0;
    ex_load_i  = 1'b0;
    ex_waddr_i = '0;
    ex_wdata_i = '0;
    wb_we_i    = 1'b0;
    wb_waddr_i = '0;
    wb_wdata_i = '0;
  endtask

  ////////////////////////////////////////
  // One pattern: present, stall check, accept, compare
  ////////////////////////////////////////

  task automatic run_pattern(input int p);
    int          base;
    int          err_start;
    int          stall;
    bit          accepted;
    bit          stall_reported;
    logic [31:0] exp_hazard;
    logic [6:0]  opcode;
    base           = p * PAT_WORDS;
    err_start      = errors;
    stall          = 0;
    accepted       = 1'b0;
    stall_reported = 1'b0;
    exp_hazard     = pat_mem[base+23];
    opcode         = pat_mem[base+1][6:0];
    rand_bp        = pat_mem[base+10][0];

    next_cycle();
    instr_valid_i = 1'b1;
    instr_i       = pat_mem[base+1];
    pc_i          = pat_mem[base+2];
    ex_we_i       = pat_mem[base+3][0];
    ex_load_i     = pat_mem[base+4][0];
    ex_waddr_i    = pat_mem[base+5][`ID_RAW-1:0];
    ex_wdata_i    = pat_mem[base+6];
    wb_we_i       = pat_mem[base+7][0];
    wb_waddr_i    = pat_mem[base+8][`ID_RAW-1:0];
    wb_wdata_i    = pat_mem[base+9];
    #1;

    while (!accepted) begin
      if (id_ready_o) begin
        if (exp_hazard[0] && stall != HOLD_CYC) begin
          $display("Pattern %0d taken while the EX load was still present", p);
          errors++;
        end
        // Target is combinational, checked while the jump is presented
        if (opcode == 7'h6f || opcode == 7'h67) begin
          compare_field("jmp_target_o", jmp_target_o, pat_mem[base+22]);
        end
        compare_field("rf_re_o", 32'(rf_re_o), 32'(reads_of(opcode, pat_mem[base+21][0])));
        accepted = 1'b1;
      end else begin
        if (!exp_hazard[0] && !stall_reported) begin
          $display("Pattern %0d stalled with no load-use hazard", p);
          errors++;
          stall_reported = 1'b1;
        end
        stall++;
        next_cycle();
        if (stall >= HOLD_CYC) begin
          // Load has left EX
          ex_we_i   = 1'b0;
          ex_load_i = 1'b0;
        end
        #1;
      end
    end

    next_cycle();
    clear_forwarding();
    offer_while_ex_stalls(base);
    while (!(ex_valid_o && ex_ready_i)) begin
      if (instr_valid_i && id_ready_o) begin
        $display("Pattern %0d: a new instruction was taken while EX stalled", p);
        errors++;
      end
      next_cycle();
      offer_while_ex_stalls(base);
    end

    compare_field("ex_pc_o", ex_pc_o, pat_mem[base+2]);
    compare_field("ex_alu_op_o", 32'(ex_alu_op_o), pat_mem[base+11]);
    compare_field("ex_operand_a_o", ex_operand_a_o, pat_mem[base+12]);
    compare_field("ex_operand_b_o", ex_operand_b_o, pat_mem[base+13]);
    compare_field("ex_operand_c_o", ex_operand_c_o, pat_mem[base+14]);
    compare_field("ex_rf_we_o", 32'(ex_rf_we_o), pat_mem[base+15]);
    compare_field("ex_rf_waddr_o", 32'(ex_rf_waddr_o), pat_mem[base+16]);
    compare_field("ex_lsu_en_o", 32'(ex_lsu_en_o), pat_mem[base+17]);
    compare_field("ex_lsu_we_o", 32'(ex_lsu_we_o), pat_mem[base+18]);
    compare_field("ex_lsu_size_o", 32'(ex_lsu_size_o), pat_mem[base+19]);
    compare_field("ex_lsu_sext_o", 32'(ex_lsu_sext_o), pat_mem[base+20]);
    compare_field("ex_illegal_o", 32'(ex_illegal_o), pat_mem[base+21]);

    // Item is gone once EX took it
    next_cycle();
    #1;
    if (ex_valid_o) begin
      $display("Pattern %0d delivered to EX more than once", p);
      errors++;
    end

    if (errors == err_start) begin
      pass_cnt++;
      $display("Test %0d pattern %0d pc 0x%h passed", pat_mem[base], p, pat_mem[base+2]);
    end else begin
      fail_cnt++;
      $display("Test %0d pattern %0d pc 0x%h failed", pat_mem[base], p, pat_mem[base+2]);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    ex_ready_i    = 1'b1;
    clear_forwarding();
    $readmemh("verif/id_stage_patterns.hex", pat_mem);
    if ($isunknown(pat_mem[NUM_PAT*PAT_WORDS-1])) begin
      $display("Pattern file is shorter than %0d patterns", NUM_PAT);
      errors++;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (ex_valid_o !== 1'b0 || id_ready_o !== 1'b1) begin
      $display("After reset ex_valid_o is %b and id_ready_o is %b", ex_valid_o, id_ready_o);
      errors++;
    end

    for (int p = 0; p < NUM_PAT; p++) begin
      run_pattern(p);
    end

    if (DUT.u_id_ex.u_props.assert_errors != 0) begin
      $display("%0d assertion failures", DUT.u_id_ex.u_props.assert_errors);
      errors++;
    end
    $display("Patterns passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* id_stage.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/fwd_if.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/operand_bypass.sv
rtl/operand_select.sv
rtl/id_ex_register.sv
rtl/id_stage.sv
verif/id_stage_props.sv
verif/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f id_stage.f \
    --top-module tb_id_stage -o sim_id_stage; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_id_stage)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verif/id_stage_patterns.hex */
// Per pattern, stimulus line: test instr pc ex_we ex_load ex_waddr ex_wdata wb_we wb_waddr wb_wdata bp
// then expected line: alu a b c rf_we waddr lsu_en lsu_we size sext illegal jmp hazard
1 002081B3 100 0 0 0 0 0 0 0 0 // add x3,x1,x2
0 10000011 10000022 10000022 1 3 0 0 0 1 0 0 0
1 407302B3 104 0 0 0 0 0 0 0 0 // sub x5,x6,x7
1 10000066 10000077 10000077 1 5 0 0 0 1 0 0 0
1 FFB10093 108 0 0 0 0 0 0 0 0 // addi x1,x2,-5
0 10000022 FFFFFFFB 0 1 1 0 0 0 1 0 0 0
1 40355413 10C 0 0 0 0 0 0 0 0 // srai x8,x10,3
7 100000AA 403 0 1 8 0 0 1 0 0 0 0
1 123453B7 110 0 0 0 0 0 0 0 0 // lui x7,0x12345
0 0 12345000 0 1 7 0 0 1 0 0 0 0
1 80000117 114 0 0 0 0 0 0 0 0 // auipc x2,0x80000
0 114 80000000 0 1 2 0 0 0 1 0 0 0
2 002081B3 118 1 0 1 AAAA0001 1 1 BBBB0001 0 // EX beats WB on x1
0 AAAA0001 10000022 10000022 1 3 0 0 0 1 0 0 0
2 00200233 11C 1 0 0 CCCC0000 1 2 BBBB0002 0 // x0 stays zero, WB on x2
0 0 BBBB0002 BBBB0002 1 4 0 0 0 1 0 0 0
3 0080A283 120 0 0 0 0 0 0 0 1 // lw x5,8(x1)
0 10000011 8 0 1 5 1 0 2 1 0 0 0
3 FE21AE23 124 0 0 0 0 0 0 0 1 // sw x2,-4(x3)
0 10000033 FFFFFFFC 10000022 0 1C 1 1 2 1 0 0 0
3 FE2098E3 128 0 0 0 0 0 0 0 1 // bne x1,x2,-16
B 10000011 10000022 118 0 11 0 0 1 1 0 0 0
3 001000EF 12C 0 0 0 0 0 0 0 0 // jal x1,+0x800
0 12C 4 0 1 1 0 0 0 1 0 92C 0
3 00530067 130 0 0 0 0 0 0 0 0 // jalr x0,5(x6)
0 130 4 0 1 0 0 0 0 1 0 1000006A 0
4 002081B3 134 1 1 2 DEAD0000 0 0 0 0 // load in EX to x2
0 10000011 10000022 10000022 1 3 0 0 0 1 0 0 1
5 0062C4B3 138 0 0 0 0 0 0 0 1 // xor x9,x5,x6
5 10000055 10000066 10000066 1 9 0 0 0 0 0 0 0
5 7FF3E513 13C 0 0 0 0 0 0 0 1 // ori x10,x7,0x7ff
8 10000077 7FF 0 1 A 0 0 2 0 0 0 0
6 0000000B 140 0 0 0 0 0 0 0 0 // custom-0 opcode
0 0 0 0 0 0 0 0 0 1 1 0 0
6 022081B3 144 0 0 0 0 0 0 0 0 // mul, no M extension
0 0 0 0 0 3 0 0 0 1 1 0 0
6 0080B283 148 0 0 0 0 0 0 0 0 // ld, not in RV32I
0 0 8 0 0 5 0 0 3 1 1 0 0
